//--- ex_pkg.sv
package ex_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int shamt_w    = 5;

    typedef logic [data_w-1:0]            word_t;
    typedef logic [2*data_w-1:0]          dword_t;  // hi:lo or full product
    typedef logic [reg_addr_w-1:0]        reg_addr_t;
    typedef logic [$clog2(data_w+1)-1:0]  count_t;  // 0 to 32

    typedef enum logic [7:0] {
        op_nop   = 8'b0000_0000,
        op_and   = 8'b0010_0100,
        op_or    = 8'b0010_0101,
        op_xor   = 8'b0010_0110,
        op_nor   = 8'b0010_0111,
        op_sll   = 8'b0111_1100,
        op_srl   = 8'b0000_0010,
        op_sra   = 8'b0000_0011,
        op_movz  = 8'b0000_1010,
        op_movn  = 8'b0000_1011,
        op_mfhi  = 8'b0001_0000,
        op_mthi  = 8'b0001_0001,
        op_mflo  = 8'b0001_0010,
        op_mtlo  = 8'b0001_0011,
        op_slt   = 8'b0010_1010,
        op_sltu  = 8'b0010_1011,
        op_add   = 8'b0010_0000,
        op_addu  = 8'b0010_0001,
        op_sub   = 8'b0010_0010,
        op_subu  = 8'b0010_0011,
        op_addi  = 8'b0101_0101,
        op_addiu = 8'b0101_0110,
        op_clz   = 8'b1011_0000,
        op_clo   = 8'b1011_0001,
        op_mult  = 8'b0001_1000,
        op_multu = 8'b0001_1001,
        op_mul   = 8'b1010_1001,
        op_madd  = 8'b1010_0110,
        op_maddu = 8'b1010_1000,
        op_msub  = 8'b1010_1010,
        op_msubu = 8'b1010_1011,
        op_jal   = 8'b0101_0000,
        op_jalr  = 8'b0000_1001
    } alu_op_e;

    typedef enum logic [2:0] {
        res_nop   = 3'b000,
        res_logic = 3'b001,
        res_shift = 3'b010,
        res_move  = 3'b011,
        res_arith = 3'b100,
        res_mul   = 3'b101,
        res_link  = 3'b110
    } alu_sel_e;

    typedef enum logic {
        mac_idle  = 1'b0,
        mac_accum = 1'b1
    } mac_state_e;

    typedef struct packed {
        alu_op_e   aluop;
        alu_sel_e  alusel;
        word_t     reg1;       // rs
        word_t     reg2;       // rt or immediate
        reg_addr_t waddr;
        logic      wen;
        word_t     link_addr;
    } ex_op_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
        logic  we;
    } hilo_wr_t;

    typedef struct packed {
        reg_addr_t waddr;
        logic      wen;
        word_t     wdata;
    } reg_wr_t;

endpackage

//--- ex_mult.sv
`timescale 1ns/1ns

module ex_mult (
    input  ex_pkg::word_t  a,
    input  ex_pkg::word_t  b,
    input  logic           is_signed,
    output ex_pkg::dword_t product
);
    import ex_pkg::*;

    word_t  a_mag;
    word_t  b_mag;
    dword_t mag_product;
    logic   negate;

    // two's complement magnitude for negative signed operands
    assign a_mag = (is_signed && a[data_w-1]) ? ~a + 1'b1 : a;
    assign b_mag = (is_signed && b[data_w-1]) ? ~b + 1'b1 : b;

    assign mag_product = dword_t'(a_mag) * dword_t'(b_mag);

    assign negate = is_signed && (a[data_w-1] ^ b[data_w-1]);

    assign product = negate ? ~mag_product + 1'b1 : mag_product;

endmodule

//--- ex_alu.sv
`timescale 1ns/1ns

module ex_alu (
    input  ex_pkg::ex_op_t op,
    output ex_pkg::word_t  alu_word,
    output logic           add_ovf
);
    import ex_pkg::*;

    word_t              rs;
    word_t              rt;
    word_t              rt_mux;
    word_t              sum;
    logic               is_sub;
    logic               rt_sign;
    logic               lt;
    logic [shamt_w-1:0] shamt;
    count_t             lead_zeros;
    count_t             lead_ones;
    word_t              logic_res;
    word_t              shift_res;
    word_t              arith_res;
    word_t              move_res;

    // count zeros from the msb down to the first set bit
    function automatic count_t count_lead(word_t w);
        count_t n;
        logic   found;
        n     = '0;
        found = 1'b0;
        for (int i = data_w - 1; i >= 0; i--) begin
            if (w[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign rs    = op.reg1;
    assign rt    = op.reg2;
    assign shamt = rs[shamt_w-1:0];

    assign is_sub = (op.aluop == op_sub) || (op.aluop == op_subu) || (op.aluop == op_slt);
    assign rt_mux = is_sub ? ~rt + 1'b1 : rt;
    assign sum    = rs + rt_mux;

    assign rt_sign = rt[data_w-1] ^ is_sub;  // sign of the added operand, rt negated for sub

    // operands of like sign giving a result of the other sign
    assign add_ovf = (!rs[data_w-1] && !rt_sign && sum[data_w-1]) ||
                     (rs[data_w-1] && rt_sign && !sum[data_w-1]);

    assign lt = (op.aluop == op_slt) ?
                ((rs[data_w-1] && !rt[data_w-1]) ||
                 (!(rs[data_w-1] ^ rt[data_w-1]) && sum[data_w-1])) :
                (rs < rt);

    assign lead_zeros = count_lead(rs);
    assign lead_ones  = count_lead(~rs);

    always_comb begin
        case (op.aluop)
            op_or:   logic_res = rs | rt;
            op_and:  logic_res = rs & rt;
            op_nor:  logic_res = ~(rs | rt);
            op_xor:  logic_res = rs ^ rt;
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op.aluop)
            op_sll:  shift_res = rt << shamt;
            op_srl:  shift_res = rt >> shamt;
            op_sra:  shift_res = word_t'($signed(rt) >>> shamt);
            default: shift_res = '0;
        endcase
    end

    always_comb begin
        case (op.aluop)
            op_slt, op_sltu:                     arith_res = word_t'(lt);
            op_add, op_addu, op_addi, op_addiu:  arith_res = sum;
            op_sub, op_subu:                     arith_res = sum;
            op_clz:                              arith_res = word_t'(lead_zeros);
            op_clo:                              arith_res = word_t'(lead_ones);
            default:                             arith_res = '0;
        endcase
    end

    // the condition itself is resolved upstream in wen
    assign move_res = ((op.aluop == op_movz) || (op.aluop == op_movn)) ? rs : '0;

    always_comb begin
        case (op.alusel)
            res_logic: alu_word = logic_res;
            res_shift: alu_word = shift_res;
            res_arith: alu_word = arith_res;
            res_move:  alu_word = move_res;
            default:   alu_word = '0;
        endcase
    end

endmodule

//--- ex_hilo.sv
`timescale 1ns/1ns

module ex_hilo (
    input  logic             clk,
    input  logic             arst_n,
    input  ex_pkg::ex_op_t   op,
    input  ex_pkg::word_t    hi,
    input  ex_pkg::word_t    lo,
    input  ex_pkg::hilo_wr_t mem_hilo,
    input  ex_pkg::hilo_wr_t wb_hilo,
    output ex_pkg::word_t    hilo_word,
    output ex_pkg::hilo_wr_t hilo_next,
    output logic             stall
);
    import ex_pkg::*;

    word_t      hi_fwd;
    word_t      lo_fwd;
    dword_t     product;
    logic       is_signed;
    logic       is_mac;
    logic       is_msub;
    mac_state_e state;
    mac_state_e state_next;
    dword_t     mac_prod;
    dword_t     mac_sum;

    // youngest pending write wins
    always_comb begin
        if (mem_hilo.we) begin
            hi_fwd = mem_hilo.hi;
            lo_fwd = mem_hilo.lo;
        end else if (wb_hilo.we) begin
            hi_fwd = wb_hilo.hi;
            lo_fwd = wb_hilo.lo;
        end else begin
            hi_fwd = hi;
            lo_fwd = lo;
        end
    end

    assign is_signed = (op.aluop == op_mul) || (op.aluop == op_mult) ||
                       (op.aluop == op_madd) || (op.aluop == op_msub);
    assign is_msub   = (op.aluop == op_msub) || (op.aluop == op_msubu);
    assign is_mac    = is_msub || (op.aluop == op_madd) || (op.aluop == op_maddu);

    ex_mult u_ex_mult (
        .a         (op.reg1),
        .b         (op.reg2),
        .is_signed (is_signed),
        .product   (product)
    );

    assign stall = is_mac && (state == mac_idle);  // first cycle of a mac

    always_comb begin
        state_next = state;
        case (state)
            mac_idle:  if (is_mac) state_next = mac_accum;
            mac_accum: state_next = mac_idle;
            default:   state_next = mac_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= mac_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            mac_prod <= is_msub ? ~product + 1'b1 : product;
        end
    end

    assign mac_sum = mac_prod + {hi_fwd, lo_fwd};  // hi/lo as seen in the second cycle

    always_comb begin
        case (op.aluop)
            op_mfhi: hilo_word = hi_fwd;
            op_mflo: hilo_word = lo_fwd;
            op_mul:  hilo_word = product[data_w-1:0];
            default: hilo_word = '0;
        endcase
    end

    always_comb begin
        hilo_next = '0;
        case (op.aluop)
            op_mult, op_multu: begin
                hilo_next = '{hi: product[2*data_w-1:data_w], lo: product[data_w-1:0], we: 1'b1};
            end
            op_mthi: hilo_next = '{hi: op.reg1, lo: lo_fwd, we: 1'b1};
            op_mtlo: hilo_next = '{hi: hi_fwd, lo: op.reg1, we: 1'b1};
            op_madd, op_maddu, op_msub, op_msubu: begin
                if (state == mac_accum) begin
                    hilo_next = '{hi: mac_sum[2*data_w-1:data_w], lo: mac_sum[data_w-1:0],
                                  we: 1'b1};
                end
            end
            default: hilo_next = '0;
        endcase
    end

endmodule

//--- ex_result.sv
`timescale 1ns/1ns

module ex_result (
    input  logic             clk,
    input  logic             arst_n,
    input  ex_pkg::ex_op_t   op,
    input  ex_pkg::word_t    alu_word,
    input  logic             add_ovf,
    input  ex_pkg::word_t    hilo_word,
    input  ex_pkg::hilo_wr_t hilo_next,
    input  logic             stall,
    output ex_pkg::reg_wr_t  reg_wr,
    output ex_pkg::hilo_wr_t hilo_wr
);
    import ex_pkg::*;

    word_t     wdata;
    logic      ovf_op;
    logic      wen;
    logic      we;
    reg_addr_t waddr_q;
    word_t     wdata_q;
    logic      wen_q;
    word_t     hi_q;
    word_t     lo_q;
    logic      we_q;

    always_comb begin
        case (op.alusel)
            res_logic, res_shift, res_arith: wdata = alu_word;
            res_move: begin
                // movz/movn are resolved in the alu
                wdata = ((op.aluop == op_mfhi) || (op.aluop == op_mflo)) ? hilo_word : alu_word;
            end
            res_mul:  wdata = hilo_word;
            res_link: wdata = op.link_addr;
            default:  wdata = '0;
        endcase
    end

    assign ovf_op = (op.aluop == op_add) || (op.aluop == op_addi) || (op.aluop == op_sub);
    assign wen    = op.wen && !(ovf_op && add_ovf) && !stall;
    assign we     = hilo_next.we && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wen_q <= 1'b0;
            we_q  <= 1'b0;
        end else begin
            wen_q <= wen;
            we_q  <= we;
        end
    end

    always_ff @(posedge clk) begin
        waddr_q <= op.waddr;
        wdata_q <= wdata;
        hi_q    <= hilo_next.hi;
        lo_q    <= hilo_next.lo;
    end

    assign reg_wr  = '{waddr: waddr_q, wen: wen_q, wdata: wdata_q};
    assign hilo_wr = '{hi: hi_q, lo: lo_q, we: we_q};

endmodule

//--- ex_stage.sv
`timescale 1ns/1ns

module ex_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  ex_pkg::ex_op_t   op,
    input  ex_pkg::word_t    hi,
    input  ex_pkg::word_t    lo,
    input  ex_pkg::hilo_wr_t mem_hilo,
    input  ex_pkg::hilo_wr_t wb_hilo,
    output ex_pkg::reg_wr_t  reg_wr,
    output ex_pkg::hilo_wr_t hilo_wr,
    output logic             stall
);
    import ex_pkg::*;

    word_t    alu_word;
    logic     add_ovf;
    word_t    hilo_word;
    hilo_wr_t hilo_next;

    ex_alu u_ex_alu (
        .op       (op),
        .alu_word (alu_word),
        .add_ovf  (add_ovf)
    );

    ex_hilo u_ex_hilo (
        .clk       (clk),
        .arst_n    (arst_n),
        .op        (op),
        .hi        (hi),
        .lo        (lo),
        .mem_hilo  (mem_hilo),
        .wb_hilo   (wb_hilo),
        .hilo_word (hilo_word),
        .hilo_next (hilo_next),
        .stall     (stall)
    );

    ex_result u_ex_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .op        (op),
        .alu_word  (alu_word),
        .add_ovf   (add_ovf),
        .hilo_word (hilo_word),
        .hilo_next (hilo_next),
        .stall     (stall),
        .reg_wr    (reg_wr),
        .hilo_wr   (hilo_wr)
    );

endmodule

//--- tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage;
    import ex_pkg::*;

    localparam int clk_period = 8;
    localparam int n_ops      = 450;  // cycles used by all tests together
    localparam int timeout_ns = n_ops * 3 * clk_period + 400;

    typedef struct packed {
        logic     valid;
        reg_wr_t  rw;
        hilo_wr_t hw;
    } expect_t;

    logic        clk = 1'b0;
    logic        arst_n;
    ex_op_t      op;
    word_t       hi;
    word_t       lo;
    hilo_wr_t    mem_hilo;
    hilo_wr_t    wb_hilo;
    reg_wr_t     reg_wr;
    hilo_wr_t    hilo_wr;
    logic        stall;
    logic [31:0] lfsr = 32'he9ee61d7;
    expect_t     pend;
    int          checks = 0;
    int          value_errs = 0;
    int          stall_errs = 0;
    alu_op_e     mix_ops [16] = '{op_and, op_or, op_xor, op_nor, op_sll, op_srl, op_sra, op_addu,
                                  op_subu, op_addiu, op_slt, op_sltu, op_movz, op_movn, op_jal,
                                  op_jalr};
    alu_op_e     ovf_ops [6] = '{op_add, op_addi, op_sub, op_addu, op_addiu, op_subu};
    word_t       ovf_a [6] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff,
                               32'h4000_0000, 32'h0000_0000};
    word_t       ovf_b [6] = '{32'h0000_0001, 32'hffff_ffff, 32'h0000_0001, 32'hffff_ffff,
                               32'h4000_0000, 32'h8000_0000};
    alu_op_e     mac_ops [4] = '{op_madd, op_maddu, op_msub, op_msubu};
    alu_op_e     fwd_ops [4] = '{op_mfhi, op_mflo, op_mthi, op_mtlo};

    ex_stage u_ex_stage (
        .clk      (clk),
        .arst_n   (arst_n),
        .op       (op),
        .hi       (hi),
        .lo       (lo),
        .mem_hilo (mem_hilo),
        .wb_hilo  (wb_hilo),
        .reg_wr   (reg_wr),
        .hilo_wr  (hilo_wr),
        .stall    (stall)
    );

    always #(clk_period / 2) clk = ~clk;

    // fibonacci lfsr with taps 32 22 2 1
    function automatic word_t rand_bits(int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic hilo_wr_t rand_hilo(logic we);
        hilo_wr_t r;
        r.hi = rand_bits(data_w);
        r.lo = rand_bits(data_w);
        r.we = we;
        return r;
    endfunction

    function automatic dword_t fwd_value(hilo_wr_t m, hilo_wr_t w, word_t h, word_t l);
        if (m.we) return {m.hi, m.lo};
        if (w.we) return {w.hi, w.lo};
        return {h, l};
    endfunction

    function automatic dword_t full_product(word_t a, word_t b, logic sgn);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = sgn ? {{32{a[31]}}, a} : {32'b0, a};
        sb = sgn ? {{32{b[31]}}, b} : {32'b0, b};
        return dword_t'(sa * sb);
    endfunction

    function automatic int lead_count(word_t w, logic bit_val);
        int n;
        n = 0;
        while (n < data_w && w[data_w-1-n] == bit_val) begin
            n++;
        end
        return n;
    endfunction

    function automatic ex_op_t make_op(alu_op_e code, word_t a, word_t b);
        ex_op_t o;
        o.aluop     = code;
        o.alusel    = res_arith;
        o.reg1      = a;
        o.reg2      = b;
        o.waddr     = reg_addr_t'(rand_bits(reg_addr_w));
        o.wen       = 1'b1;
        o.link_addr = rand_bits(data_w);
        case (code)
            op_and, op_or, op_xor, op_nor:      o.alusel = res_logic;
            op_sll, op_srl, op_sra:             o.alusel = res_shift;
            op_movz, op_movn, op_mfhi, op_mflo: o.alusel = res_move;
            op_mul:                             o.alusel = res_mul;
            op_jal, op_jalr:                    o.alusel = res_link;
            op_nop, op_mthi, op_mtlo, op_mult, op_multu, op_madd, op_maddu, op_msub,
            op_msubu: begin
                o.alusel = (code == op_mthi || code == op_mtlo) ? res_move : res_nop;
                o.wen    = 1'b0;
            end
            default: ;
        endcase
        if (code == op_movz) o.wen = (b == '0);  // move condition is decided upstream
        if (code == op_movn) o.wen = (b != '0);
        return o;
    endfunction

    function automatic expect_t model(ex_op_t o, dword_t fwd);
        expect_t     e;
        logic [32:0] wide;
        dword_t      prod;
        word_t       a;
        word_t       b;
        a          = o.reg1;
        b          = o.reg2;
        e          = '0;
        e.valid    = 1'b1;
        e.rw.waddr = o.waddr;
        e.rw.wen   = o.wen;
        prod       = full_product(a, b, o.aluop != op_multu);
        case (o.aluop)
            op_and:            e.rw.wdata = a & b;
            op_or:             e.rw.wdata = a | b;
            op_xor:            e.rw.wdata = a ^ b;
            op_nor:            e.rw.wdata = ~(a | b);
            op_sll:            e.rw.wdata = b << a[4:0];
            op_srl:            e.rw.wdata = b >> a[4:0];
            op_sra:            e.rw.wdata = word_t'($signed(b) >>> a[4:0]);
            op_add, op_addi, op_sub: begin
                wide = (o.aluop == op_sub) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
                e.rw.wdata = wide[31:0];
                if (wide[32] != wide[31]) e.rw.wen = 1'b0;  // signed overflow
            end
            op_addu, op_addiu: e.rw.wdata = a + b;
            op_subu:           e.rw.wdata = a - b;
            op_slt:            e.rw.wdata = word_t'($signed(a) < $signed(b));
            op_sltu:           e.rw.wdata = word_t'(a < b);
            op_clz:            e.rw.wdata = word_t'(lead_count(a, 1'b0));
            op_clo:            e.rw.wdata = word_t'(lead_count(a, 1'b1));
            op_movz, op_movn:  e.rw.wdata = a;
            op_jal, op_jalr:   e.rw.wdata = o.link_addr;
            op_mfhi:           e.rw.wdata = fwd[63:32];
            op_mflo:           e.rw.wdata = fwd[31:0];
            op_mthi:           e.hw = '{hi: a, lo: fwd[31:0], we: 1'b1};
            op_mtlo:           e.hw = '{hi: fwd[63:32], lo: a, we: 1'b1};
            op_mult, op_multu: e.hw = '{hi: prod[63:32], lo: prod[31:0], we: 1'b1};
            op_mul:            e.rw.wdata = prod[31:0];
            default: ;
        endcase
        return e;
    endfunction

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, expected,
                     actual);
            value_errs++;
        end
    endtask

    task automatic check_stall(input logic expected);
        checks++;
        assert (stall === expected) else begin
            $display("** Error at %0t ns: stall expected %b, actual %b", $time, expected, stall);
            stall_errs++;
        end
    endtask

    task automatic compare_pending();
        if (pend.valid) begin
            check_val("reg_wr.wen", pend.rw.wen, reg_wr.wen);
            if (pend.rw.wen) begin
                check_val("reg_wr.waddr", pend.rw.waddr, reg_wr.waddr);
                check_val("reg_wr.wdata", pend.rw.wdata, reg_wr.wdata);
            end
            check_val("hilo_wr.we", pend.hw.we, hilo_wr.we);
            if (pend.hw.we) begin
                check_val("hilo_wr.hi", pend.hw.hi, hilo_wr.hi);
                check_val("hilo_wr.lo", pend.hw.lo, hilo_wr.lo);
            end
        end
    endtask

    // outputs seen at this negedge belong to the op issued one edge earlier
    task automatic issue(input ex_op_t o, input hilo_wr_t m, input hilo_wr_t w);
        word_t h;
        word_t l;
        h = rand_bits(data_w);
        l = rand_bits(data_w);
        @(posedge clk);
        op       <= o;
        mem_hilo <= m;
        wb_hilo  <= w;
        hi       <= h;
        lo       <= l;
        @(negedge clk);
        compare_pending();
        check_stall(1'b0);
        pend = model(o, fwd_value(m, w, h, l));
    endtask

    task automatic issue_mac(input alu_op_e code, input word_t a, input word_t b,
                             input hilo_wr_t m, input hilo_wr_t w);
        ex_op_t o;
        dword_t prod;
        word_t  h;
        word_t  l;
        o    = make_op(code, a, b);
        prod = full_product(a, b, code == op_madd || code == op_msub);
        if (code == op_msub || code == op_msubu) begin
            prod = -prod;
        end
        @(posedge clk);
        op       <= o;
        mem_hilo <= rand_hilo(rand_bits(1) != '0);  // replaced before the accumulate cycle
        wb_hilo  <= rand_hilo(1'b1);
        @(negedge clk);
        compare_pending();
        check_stall(1'b1);
        pend       = '0;
        pend.valid = 1'b1;
        h          = rand_bits(data_w);
        l          = rand_bits(data_w);
        @(posedge clk);
        op       <= o;  // held through the stall
        mem_hilo <= m;
        wb_hilo  <= w;
        hi       <= h;
        lo       <= l;
        @(negedge clk);
        compare_pending();
        check_stall(1'b0);
        prod       = prod + fwd_value(m, w, h, l);
        pend       = '0;
        pend.valid = 1'b1;
        pend.hw    = '{hi: prod[63:32], lo: prod[31:0], we: 1'b1};
    endtask

    initial begin
        word_t a;
        word_t b;
        arst_n   = 1'b0;
        op       = '0;
        hi       = '0;
        lo       = '0;
        mem_hilo = '0;
        wb_hilo  = '0;
        pend     = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_val("reg_wr.wen", 1'b0, reg_wr.wen);
        check_val("hilo_wr.we", 1'b0, hilo_wr.we);
        check_stall(1'b0);
        @(posedge clk);
        arst_n <= 1'b1;

        for (int i = 0; i < 160; i++) begin
            a = rand_bits(data_w);
            b = (rand_bits(2) == '0) ? '0 : rand_bits(data_w);  // zero rt for movz
            issue(make_op(mix_ops[rand_bits(4)], a, b), rand_hilo(1'b0), rand_hilo(1'b0));
        end
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                issue(make_op(ovf_ops[j], ovf_a[i], ovf_b[i]), rand_hilo(1'b0), rand_hilo(1'b0));
            end
        end
        for (int i = 0; i <= 32; i++) begin
            issue(make_op(op_clz, 32'hffff_ffff >> i, '0), rand_hilo(1'b0), rand_hilo(1'b0));
            issue(make_op(op_clo, 32'hffff_ffff << i, '0), rand_hilo(1'b0), rand_hilo(1'b0));
            issue(make_op(op_clz, word_t'(1) << i, '0), rand_hilo(1'b0), rand_hilo(1'b0));
        end
        for (int i = 0; i < 10; i++) begin
            a = rand_bits(data_w) >> rand_bits(5);
            issue(make_op(op_clz, a, '0), rand_hilo(1'b0), rand_hilo(1'b0));
            issue(make_op(op_clo, ~a, '0), rand_hilo(1'b0), rand_hilo(1'b0));
        end
        for (int i = 0; i < 20; i++) begin
            a = rand_bits(data_w) | ((i % 2) ? 32'h8000_0000 : '0);
            b = rand_bits(data_w) | ((i % 4) < 2 ? 32'h8000_0000 : '0);
            issue(make_op(op_mult, a, b), rand_hilo(1'b0), rand_hilo(1'b0));
            issue(make_op(op_multu, a, b), rand_hilo(1'b0), rand_hilo(1'b0));
            issue(make_op(op_mul, a, b), rand_hilo(1'b0), rand_hilo(1'b0));
        end
        for (int i = 0; i < 16; i++) begin
            a = rand_bits(data_w);
            b = rand_bits(data_w);
            issue_mac(mac_ops[rand_bits(2)], a, b, rand_hilo(i[0]), rand_hilo(i[1]));
        end
        for (int i = 0; i < 32; i++) begin
            a = rand_bits(data_w);
            issue(make_op(fwd_ops[i[3:2]], a, '0), rand_hilo(i[0]), rand_hilo(i[1]));
        end
        issue(make_op(op_nop, '0, '0), rand_hilo(1'b0), rand_hilo(1'b0));
        issue(make_op(op_nop, '0, '0), rand_hilo(1'b0), rand_hilo(1'b0));

        $display("checks %0d, value errors %0d, stall errors %0d", checks, value_errs,
                 stall_errs);
        if (value_errs == 0 && stall_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns before the tests completed", timeout_ns);
        $display("tests failed");
        $finish;
    end

endmodule

//--- ex_stage.f
ex_pkg.sv
ex_mult.sv
ex_alu.sv
ex_hilo.sv
ex_result.sv
ex_stage.sv
tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - ex_pkg.sv
  - ex_mult.sv
  - ex_alu.sv
  - ex_hilo.sv
  - ex_result.sv
  - ex_stage.sv
  - target: test
    files:
      - tb_ex_stage.sv
